// ==== Makefile ====
# Verilator flow for the lane merge unit

TOOL       = verilator
FILELIST   = verilog.f
TOP        = tb_merge_top
RTL_TOP    = merge_generator_top
LINT_FLAGS = --lint-only -Wall --timescale 1ns/1ps
SIM_FLAGS  = --binary --timing --assert --timescale 1ns/1ps -Wno-fatal
RUN_FLAGS  = +verilator+error+limit+1000
BUILD_DIR  = obj_dir
LOG        = sim.log
FAIL_MSG   = Regression failed
PASS_MSG   = Regression passed

.PHONY: all lint sim clean

all: sim

lint:
	$(TOOL) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

sim:
	$(TOOL) $(SIM_FLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) $(RUN_FLAGS) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "Simulation reported a failure, see $(LOG)"; exit 1; \
	fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then \
		echo "Simulation ended without a verdict, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== dv/merge_checker.sv ====
/*
 * Assertions on the merge unit top level
 *   output packet held while stalled
 *   single-cycle configuration request
 *   done low while an output is pending
 *   output packets only while a run is in progress
 */
module merge_checker (
    input  logic                       ap_clk,
    input  logic                       areset_generator,
    input  merge_pkg::engine_packet_t  out_pkt,
    input  logic                       out_ready,
    input  logic                       cfg_req,
    input  logic                       done,
    input  merge_pkg::merge_state_t    state
);

timeunit 1ns;
timeprecision 1ps;

import merge_pkg::*;

// Read by the testbench at the end of the run
int failures = 0;

// Consumer stall must not disturb the offered packet
hold_when_stalled: assert property (
    @(posedge ap_clk) disable iff (areset_generator)
    (out_pkt.valid && !out_ready) |=> $stable(out_pkt)
) else begin
    failures++;
    $error("out_pkt changed while the consumer stalled it");
end

cfg_req_pulse: assert property (
    @(posedge ap_clk) disable iff (areset_generator)
    cfg_req |=> !cfg_req
) else begin
    failures++;
    $error("cfg_req held high for more than one cycle");
end

done_while_output: assert property (
    @(posedge ap_clk) disable iff (areset_generator)
    out_pkt.valid |-> !done
) else begin
    failures++;
    $error("done high while an output packet is pending");
end

// Merged packets leave only between the first merge and the end of the drain
out_during_run: assert property (
    @(posedge ap_clk) disable iff (areset_generator)
    out_pkt.valid |-> (state == BUSY || state == PAUSE || state == DRAIN)
) else begin
    failures++;
    $error("out_pkt valid outside a merge run");
end

endmodule : merge_checker

bind merge_generator_top merge_checker u_checker (
    .ap_clk           (ap_clk),
    .areset_generator (areset_generator),
    .out_pkt          (out_pkt),
    .out_ready        (out_ready),
    .cfg_req          (cfg_req),
    .done             (done),
    .state            (state)
);

// ==== dv/tb_merge_top.sv ====
/*
 * Directed testbench for the lane merge unit
 *   clock, reset and cycle watchdog
 *   lane senders, configuration responder, output monitor
 *   reference merge model and compare tasks
 *   done, full, masked, back-pressure and back-to-back tests
 */
`include "merge_defs.svh"

module tb_merge_top;

timeunit 1ns;
timeprecision 1ps;

import merge_pkg::*;

localparam int NL = `MERGE_NUM_LANES;
localparam int NF = `MERGE_NUM_FIELDS;
localparam logic [31:0] SEED = 32'he231dd10;

// Packets per run
localparam int DONE_N = 4;
localparam int FULL_N = 12;
localparam int MASK_N = 10;
localparam int BP_N = 40;
localparam int B2B_A_N = 6;
localparam int B2B_B_N = 9;
localparam int NUM_RUNS = 6;
localparam int TOTAL_PKTS = DONE_N + FULL_N + MASK_N + BP_N + B2B_A_N + B2B_B_N;
// Slow consumer takes about four cycles per packet, so thirty is ample
localparam int CYCLE_LIMIT = TOTAL_PKTS * 30 + NUM_RUNS * 60 + 50;

logic              ap_clk;
logic              areset;
merge_descriptor_t descriptor_in;
merge_config_t     cfg_in;
engine_packet_t    lane_in [NL];
logic [NL-1:0]     lane_ready;
logic              cfg_req;
engine_packet_t    out_pkt;
logic              out_ready;
logic              done;

int              errors = 0;
int              checks = 0;
int              cycles = 0;
int              received = 0;
int              tag = 0;
bit              slow_ready = 1'b0;
bit              saw_lane_stall = 1'b0;
engine_payload_t expected_q [$];

merge_generator_top dut0 (
    .ap_clk        (ap_clk),
    .areset        (areset),
    .descriptor_in (descriptor_in),
    .cfg_in        (cfg_in),
    .lane_in       (lane_in),
    .lane_ready    (lane_ready),
    .cfg_req       (cfg_req),
    .out_pkt       (out_pkt),
    .out_ready     (out_ready),
    .done          (done)
);

initial begin
    ap_clk = 1'b0;
    forever #20 ap_clk = ~ap_clk;
end

// ----------------------------------------
// Compare tasks and reference model
// ----------------------------------------
task automatic compare_packet(input engine_packet_t actual, input engine_packet_t expected,
                              input string what);
    checks++;
    if (actual !== expected) begin
        errors++;
        $display("ERR %0t: %s got %h expected %h", $time, what, actual, expected);
    end
endtask

task automatic compare_done(input logic actual, input logic expected, input string what);
    checks++;
    if (actual !== expected) begin
        errors++;
        $display("ERR %0t: %s got done=%b expected %b", $time, what, actual, expected);
    end
endtask

// Meta and high fields from lane 0, field j from lane j when enabled
function automatic engine_payload_t build_expected(input engine_payload_t pl [NL],
                                                   input logic [NL-1:0] mask);
    engine_payload_t exp;
    exp = pl[0];
    // Field 0 is lane 0 field 0 whatever mask bit 0 says
    for (int j = 1; j < NL; j++) begin
        if (mask[j]) begin
            exp.field[j] = pl[j].field[0];
        end
    end
    return exp;
endfunction

// ----------------------------------------
// Drivers
// ----------------------------------------
task automatic idle_lanes();
    for (int i = 0; i < NL; i++) begin
        lane_in[i].valid <= 1'b0;
    end
endtask

// One packet per lane per step, all lanes in the same cycle
task automatic send_lanes(input int n, input logic [NL-1:0] mask, input bit gaps);
    engine_payload_t pl [NL];
    for (int k = 0; k < n; k++) begin
        for (int i = 0; i < NL; i++) begin
            pl[i].meta = {4'(i), 12'(tag)};
            for (int j = 0; j < NF; j++) begin
                pl[i].field[j] = $urandom();
            end
        end
        tag++;
        expected_q.push_back(build_expected(pl, mask));
        while (lane_ready != '1 || (gaps && $urandom_range(0, 3) == 0)) begin
            idle_lanes();
            @(posedge ap_clk);
        end
        for (int i = 0; i < NL; i++) begin
            lane_in[i] <= '{valid: 1'b1, payload: pl[i]};
        end
        @(posedge ap_clk);
    end
    idle_lanes();
endtask

task automatic answer_config(input logic [NL-1:0] mask);
    int waited;
    waited = 0;
    while (!cfg_req && waited < 10) begin
        @(posedge ap_clk);
        waited++;
    end
    if (!cfg_req) begin
        errors++;
        $display("No configuration request within %0d cycles of the descriptor", waited);
    end else begin
        compare_done(done, 1'b0, "done at configuration request");
        repeat ($urandom_range(0, 3)) @(posedge ap_clk);
        cfg_in <= '{valid: 1'b1, mask: mask};
        @(posedge ap_clk);
        cfg_in.valid <= 1'b0;
    end
endtask

task automatic wait_outputs(input int n);
    while (received < n) begin
        @(posedge ap_clk);
        compare_done(done, 1'b0, "done during run");
    end
endtask

task automatic wait_done();
    int waited;
    waited = 0;
    while (!done && waited < 20) begin
        @(posedge ap_clk);
        waited++;
    end
    compare_done(done, 1'b1, "done after run");
    if (expected_q.size() != 0) begin
        errors++;
        $display("%0d expected packets never came out", expected_q.size());
    end
endtask

task automatic run_merge(input int n, input logic [NL-1:0] mask, input bit gaps);
    logic [`MERGE_COUNT_W-1:0] count;
    count = n[`MERGE_COUNT_W-1:0];
    received = 0;
    @(posedge ap_clk);
    descriptor_in <= '{valid: 1'b1, count: count};
    @(posedge ap_clk);
    descriptor_in.valid <= 1'b0;
    fork
        answer_config(mask);
        send_lanes(n, mask, gaps);
    join
    wait_outputs(n);
    wait_done();
endtask

// ----------------------------------------
// Tests
// ----------------------------------------
task automatic test_done_behavior();
    compare_done(done, 1'b1, "done after reset");
    run_merge(DONE_N, 4'b0101, 1'b0);
endtask

task automatic test_full_merge();
    run_merge(FULL_N, 4'b1111, 1'b0);
endtask

// Lanes 2 and 3 off, lane 0 left to the forced bit
task automatic test_masked_lanes();
    run_merge(MASK_N, 4'b0010, 1'b0);
endtask

task automatic test_back_pressure();
    slow_ready = 1'b1;
    saw_lane_stall = 1'b0;
    run_merge(BP_N, 4'b1111, 1'b1);
    slow_ready = 1'b0;
    if (!saw_lane_stall) begin
        errors++;
        $display("Back-pressure never reached the lane inputs");
    end
endtask

task automatic test_back_to_back();
    run_merge(B2B_A_N, 4'b1011, 1'b0);
    run_merge(B2B_B_N, 4'b0100, 1'b0);
endtask

// ----------------------------------------
// Consumer, monitor and watchdog
// ----------------------------------------
initial begin
    out_ready = 1'b1;
    forever begin
        @(posedge ap_clk);
        if (slow_ready) begin
            out_ready <= ($urandom_range(0, 3) == 0);
        end else begin
            out_ready <= 1'b1;
        end
    end
end

initial begin
    engine_packet_t want;
    forever begin
        @(posedge ap_clk);
        if (out_pkt.valid && out_ready) begin
            if (expected_q.size() == 0) begin
                errors++;
                $display("Output packet at %0t with nothing expected", $time);
            end else begin
                want = '{valid: 1'b1, payload: expected_q.pop_front()};
                compare_packet(out_pkt, want, "merged packet");
            end
            received++;
        end
        if (lane_ready != '1) begin
            saw_lane_stall = 1'b1;
        end
    end
end

initial begin
    while (cycles < CYCLE_LIMIT) begin
        @(posedge ap_clk);
        cycles++;
    end
    $display("Timeout after %0d cycles, the run did not finish", cycles);
    $display("Summary: %0d checks, %0d errors", checks, errors);
    $display("Regression failed");
    $finish;
end

// ----------------------------------------
// Main sequence
// ----------------------------------------
initial begin
    void'($urandom(SEED));
    areset = 1'b1;
    descriptor_in = '0;
    cfg_in = '0;
    for (int i = 0; i < NL; i++) begin
        lane_in[i] = '0;
    end
    repeat (3) @(posedge ap_clk);
    areset <= 1'b0;
    repeat (3) @(posedge ap_clk);

    test_done_behavior();
    test_full_merge();
    test_masked_lanes();
    test_back_pressure();
    test_back_to_back();

    repeat (2) @(posedge ap_clk);
    $display("Summary: %0d checks, %0d errors, %0d assertion failures",
             checks, errors, dut0.u_checker.failures);
    if (errors == 0 && dut0.u_checker.failures == 0) begin
        $display("Regression passed");
    end else begin
        $display("Regression failed");
    end
    $finish;
end

endmodule : tb_merge_top

// ==== hw/merge_collector.sv ====
/*
 * Lane collector
 *   per-lane holding flags and pop decisions
 *   discard of heads on masked-off lanes
 *   assembly register and merged packet push
 */
`include "merge_defs.svh"

module merge_collector (
    input  logic                          ap_clk,
    input  logic                          areset_generator,
    input  merge_pkg::engine_payload_t    lane_head [`MERGE_NUM_LANES],
    input  logic [`MERGE_NUM_LANES-1:0]   lane_empty,
    input  logic [`MERGE_NUM_LANES-1:0]   run_mask,
    input  logic                          merge_active,
    input  logic                          out_almost_full,
    output logic [`MERGE_NUM_LANES-1:0]   lane_pop,
    output merge_pkg::engine_packet_t     merged,
    output logic                          merge_fire
);

import merge_pkg::*;

logic [`MERGE_NUM_LANES-1:0]  held;
logic                         all_held;
logic [`MERGE_NUM_FIELDS-1:0] from_lane;
engine_payload_t              asm_q;

// ----------------------------------------
// Pop decisions
// ----------------------------------------
always_comb begin
    for (int i = 0; i < `MERGE_NUM_LANES; i++) begin
        if (run_mask[i]) begin
            // One head per merge, and none while the output backs up
            lane_pop[i] = merge_active && !lane_empty[i] && !held[i] && !out_almost_full;
        end else begin
            // Masked-off lanes are drained
            lane_pop[i] = merge_active && !lane_empty[i];
        end
    end
end

// Disabled lanes count as held
assign all_held   = &(held | ~run_mask);
assign merge_fire = merge_active && all_held;

always_ff @(posedge ap_clk) begin
    if (areset_generator) begin
        held <= '0;
    end else if (!merge_active || merge_fire) begin
        held <= '0;
    end else begin
        for (int i = 0; i < `MERGE_NUM_LANES; i++) begin
            if (lane_pop[i] && run_mask[i]) begin
                held[i] <= 1'b1;
            end
        end
    end
end

// ----------------------------------------
// Assembly
// ----------------------------------------
// Field j taken from lane j, only for enabled lanes above lane 0
always_comb begin
    from_lane = '0;
    for (int j = 1; j < `MERGE_NUM_LANES; j++) begin
        from_lane[j] = run_mask[j];
    end
end

always_ff @(posedge ap_clk) begin
    // lane 0 brings meta, field 0, high fields and the fields of disabled lanes
    if (lane_pop[0]) begin
        asm_q.meta <= lane_head[0].meta;
        for (int j = 0; j < `MERGE_NUM_FIELDS; j++) begin
            if (!from_lane[j]) begin
                asm_q.field[j] <= lane_head[0].field[j];
            end
        end
    end
    for (int i = 1; i < `MERGE_NUM_LANES; i++) begin
        if (lane_pop[i] && run_mask[i]) begin
            asm_q.field[i] <= lane_head[i].field[0];
        end
    end
end

// Push goes out the cycle after the last required pop
assign merged = '{valid: merge_fire, payload: asm_q};

endmodule : merge_collector

// ==== hw/merge_control_fsm.sv ====
/*
 * Merge sequencer
 *   descriptor capture and configuration request
 *   mask capture with lane 0 always enabled
 *   run, pause on output almost-full, drain and done
 *   merge counting against the descriptor count
 */
`include "merge_defs.svh"

module merge_control_fsm (
    input  logic                          ap_clk,
    input  logic                          areset_generator,
    input  merge_pkg::merge_descriptor_t  descriptor,
    input  merge_pkg::merge_config_t      cfg,
    input  logic                          merge_fire,
    input  logic                          out_almost_full,
    input  logic                          lanes_empty,
    input  logic                          out_drained,
    output logic                          cfg_req,
    output logic [`MERGE_NUM_LANES-1:0]   run_mask,
    output logic                          merge_active,
    output merge_pkg::merge_state_t       state,
    output logic                          done
);

import merge_pkg::*;

merge_state_t              next_state;
logic [`MERGE_COUNT_W-1:0] target_count;
logic [`MERGE_COUNT_W-1:0] fire_count;
logic                      last_fire;
logic                      buffers_empty;

// The final merge of the run, leaves BUSY or PAUSE in the next cycle
assign last_fire     = merge_fire && (fire_count == target_count - 1'b1);
assign buffers_empty = lanes_empty && out_drained;

// ----------------------------------------
// State register
// ----------------------------------------
always_ff @(posedge ap_clk) begin
    if (areset_generator) begin
        state <= IDLE;
    end else begin
        state <= next_state;
    end
end

always_comb begin
    next_state = state;
    case (state)
        IDLE: begin
            if (descriptor.valid) begin
                next_state = CFG_REQ;
            end
        end
        CFG_REQ:  next_state = CFG_WAIT;
        CFG_WAIT: begin
            if (cfg.valid) begin
                next_state = START;
            end
        end
        // Zero count has nothing to merge
        START:    next_state = (target_count == '0) ? DRAIN : BUSY;
        BUSY: begin
            if (last_fire) begin
                next_state = DRAIN;
            end else if (out_almost_full) begin
                next_state = PAUSE;
            end
        end
        PAUSE: begin
            if (last_fire) begin
                next_state = DRAIN;
            end else if (!out_almost_full) begin
                next_state = BUSY;
            end
        end
        DRAIN: begin
            if (buffers_empty) begin
                next_state = DONE;
            end
        end
        DONE:     next_state = IDLE;
        default:  next_state = IDLE;
    endcase
end

// ----------------------------------------
// Run parameters and merge count
// ----------------------------------------
always_ff @(posedge ap_clk) begin
    if (state == IDLE && descriptor.valid) begin
        target_count <= descriptor.count;
    end
end

always_ff @(posedge ap_clk) begin
    if (areset_generator) begin
        fire_count <= '0;
        run_mask   <= '1;
    end else begin
        if (state == IDLE && descriptor.valid) begin
            fire_count <= '0;
        end else if (merge_fire) begin
            fire_count <= fire_count + 1'b1;
        end
        if (state == CFG_WAIT && cfg.valid) begin
            run_mask    <= cfg.mask;
            // Lane 0 always supplies meta
            run_mask[0] <= 1'b1;
        end
    end
end

assign cfg_req      = (state == CFG_REQ);
assign merge_active = (state == START) || (state == BUSY) || (state == PAUSE);
assign done         = ((state == IDLE) || (state == DONE)) && buffers_empty;

endmodule : merge_control_fsm

// ==== hw/merge_generator_top.sv ====
/*
 * Lane merge unit top level
 *   reset and input registers
 *   one input FIFO per lane
 *   sequencer, collector and output stage
 */
`include "merge_defs.svh"

module merge_generator_top (
    input  logic                          ap_clk,
    input  logic                          areset,
    input  merge_pkg::merge_descriptor_t  descriptor_in,
    input  merge_pkg::merge_config_t      cfg_in,
    input  merge_pkg::engine_packet_t     lane_in [`MERGE_NUM_LANES],
    output logic [`MERGE_NUM_LANES-1:0]   lane_ready,
    output logic                          cfg_req,
    output merge_pkg::engine_packet_t     out_pkt,
    input  logic                          out_ready,
    output logic                          done
);

import merge_pkg::*;

logic                        areset_generator;
merge_descriptor_t           desc_q;
merge_config_t               cfg_q;
engine_packet_t              lane_q [`MERGE_NUM_LANES];
engine_payload_t             lane_head [`MERGE_NUM_LANES];
logic [`MERGE_NUM_LANES-1:0] lane_empty;
logic [`MERGE_NUM_LANES-1:0] lane_almost_full;
logic [`MERGE_NUM_LANES-1:0] lane_pop;
logic                        lanes_empty;
logic [`MERGE_NUM_LANES-1:0] run_mask;
logic                        merge_active;
logic                        merge_fire;
engine_packet_t              merged;
logic                        out_almost_full;
logic                        out_drained;
merge_state_t                state;

// ----------------------------------------
// Reset and input registers
// ----------------------------------------
always_ff @(posedge ap_clk) begin
    areset_generator <= areset;
end

always_ff @(posedge ap_clk) begin
    desc_q.count <= descriptor_in.count;
    cfg_q.mask   <= cfg_in.mask;
    for (int i = 0; i < `MERGE_NUM_LANES; i++) begin
        lane_q[i].payload <= lane_in[i].payload;
    end
    if (areset_generator) begin
        desc_q.valid <= 1'b0;
        cfg_q.valid  <= 1'b0;
        for (int i = 0; i < `MERGE_NUM_LANES; i++) begin
            lane_q[i].valid <= 1'b0;
        end
    end else begin
        desc_q.valid <= descriptor_in.valid;
        cfg_q.valid  <= cfg_in.valid;
        for (int i = 0; i < `MERGE_NUM_LANES; i++) begin
            lane_q[i].valid <= lane_in[i].valid;
        end
    end
end

// ----------------------------------------
// Lane FIFOs
// ----------------------------------------
for (genvar i = 0; i < `MERGE_NUM_LANES; i++) begin : g_lane
    sync_fifo u_lane_fifo (
        .ap_clk           (ap_clk),
        .areset_generator (areset_generator),
        .din              (lane_q[i].payload),
        .push             (lane_q[i].valid),
        .pop              (lane_pop[i]),
        .dout             (lane_head[i]),
        .empty            (lane_empty[i]),
        .full             (),
        .almost_full      (lane_almost_full[i])
    );
end

// Threshold below depth leaves room for the input register in flight
assign lane_ready  = ~lane_almost_full;
assign lanes_empty = &lane_empty;

merge_control_fsm u_fsm (
    .ap_clk           (ap_clk),
    .areset_generator (areset_generator),
    .descriptor       (desc_q),
    .cfg              (cfg_q),
    .merge_fire       (merge_fire),
    .out_almost_full  (out_almost_full),
    .lanes_empty      (lanes_empty),
    .out_drained      (out_drained),
    .cfg_req          (cfg_req),
    .run_mask         (run_mask),
    .merge_active     (merge_active),
    .state            (state),
    .done             (done)
);

merge_collector u_collector (
    .ap_clk           (ap_clk),
    .areset_generator (areset_generator),
    .lane_head        (lane_head),
    .lane_empty       (lane_empty),
    .run_mask         (run_mask),
    .merge_active     (merge_active),
    .out_almost_full  (out_almost_full),
    .lane_pop         (lane_pop),
    .merged           (merged),
    .merge_fire       (merge_fire)
);

output_stage u_output (
    .ap_clk           (ap_clk),
    .areset_generator (areset_generator),
    .merged           (merged),
    .out_ready        (out_ready),
    .out_pkt          (out_pkt),
    .out_almost_full  (out_almost_full),
    .out_drained      (out_drained)
);

endmodule : merge_generator_top

// ==== hw/merge_pkg.sv ====
/*
 * Types of the lane merge unit
 *   engine payload and engine packet
 *   kernel descriptor with merge count
 *   merge configuration with lane mask
 *   sequencer state encoding
 */
`include "merge_defs.svh"

package merge_pkg;

    // ----------------------------------------
    // Engine packets
    // ----------------------------------------
    typedef struct packed {
        logic [`MERGE_META_W-1:0]                         meta;
        logic [`MERGE_NUM_FIELDS-1:0][`MERGE_FIELD_W-1:0] field;
    } engine_payload_t;

    typedef struct packed {
        logic            valid;
        engine_payload_t payload;
    } engine_packet_t;

    // ----------------------------------------
    // Run setup
    // ----------------------------------------
    // Number of merged packets for one run
    typedef struct packed {
        logic                      valid;
        logic [`MERGE_COUNT_W-1:0] count;
    } merge_descriptor_t;

    // One mask bit per lane, bit 0 is lane 0
    typedef struct packed {
        logic                        valid;
        logic [`MERGE_NUM_LANES-1:0] mask;
    } merge_config_t;

    typedef enum logic [2:0] {
        IDLE,
        CFG_REQ,
        CFG_WAIT,
        START,
        BUSY,
        PAUSE,
        DRAIN,
        DONE
    } merge_state_t;

endpackage : merge_pkg

// ==== hw/output_stage.sv ====
/*
 * Output stage
 *   output FIFO for merged packets
 *   holding register toward the consumer with back-pressure
 */
module output_stage (
    input  logic                       ap_clk,
    input  logic                       areset_generator,
    input  merge_pkg::engine_packet_t  merged,
    input  logic                       out_ready,
    output merge_pkg::engine_packet_t  out_pkt,
    output logic                       out_almost_full,
    output logic                       out_drained
);

import merge_pkg::*;

engine_payload_t fifo_head;
logic            fifo_empty;
logic            fifo_pop;

// Load when the register is free or handed over this cycle
assign fifo_pop = !fifo_empty && (!out_pkt.valid || out_ready);

sync_fifo u_out_fifo (
    .ap_clk           (ap_clk),
    .areset_generator (areset_generator),
    .din              (merged.payload),
    .push             (merged.valid),
    .pop              (fifo_pop),
    .dout             (fifo_head),
    .empty            (fifo_empty),
    .full             (),
    .almost_full      (out_almost_full)
);

// ----------------------------------------
// Holding register
// ----------------------------------------
always_ff @(posedge ap_clk) begin
    if (fifo_pop) begin
        out_pkt.payload <= fifo_head;
    end
    if (areset_generator) begin
        out_pkt.valid <= 1'b0;
    end else if (fifo_pop) begin
        out_pkt.valid <= 1'b1;
    end else if (out_ready) begin
        out_pkt.valid <= 1'b0;
    end
end

assign out_drained = fifo_empty && !out_pkt.valid;

endmodule : output_stage

// ==== hw/sync_fifo.sv ====
/*
 * Synchronous first-word-fall-through FIFO
 *   circular buffer with read and write pointers
 *   occupancy count driving empty, full and almost-full
 */
`include "merge_defs.svh"

module sync_fifo #(
    parameter int DEPTH       = `MERGE_FIFO_DEPTH,
    parameter int PROG_THRESH = `MERGE_PROG_THRESH,
    parameter int WIDTH       = $bits(merge_pkg::engine_payload_t)
) (
    input  logic             ap_clk,
    input  logic             areset_generator,
    input  logic [WIDTH-1:0] din,
    input  logic             push,
    input  logic             pop,
    output logic [WIDTH-1:0] dout,
    output logic             empty,
    output logic             full,
    output logic             almost_full
);

localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
localparam int CW = $clog2(DEPTH + 1);

logic [WIDTH-1:0] mem [DEPTH];
logic [AW-1:0]    wr_ptr;
logic [AW-1:0]    rd_ptr;
logic [CW-1:0]    count;
logic             do_push;
logic             do_pop;

// Wraps at DEPTH so any depth works, not only powers of two
function automatic logic [AW-1:0] ptr_next(input logic [AW-1:0] ptr);
    if (ptr == AW'(DEPTH - 1)) begin
        return '0;
    end
    return ptr + 1'b1;
endfunction

// Overflow and underflow requests are dropped
assign do_push = push && !full;
assign do_pop  = pop && !empty;

// ----------------------------------------
// Storage
// ----------------------------------------
always_ff @(posedge ap_clk) begin
    if (do_push) begin
        mem[wr_ptr] <= din;
    end
end

// Head word straight from the array
assign dout = mem[rd_ptr];

// ----------------------------------------
// Pointers and occupancy
// ----------------------------------------
always_ff @(posedge ap_clk) begin
    if (areset_generator) begin
        wr_ptr <= '0;
        rd_ptr <= '0;
        count  <= '0;
    end else begin
        if (do_push) begin
            wr_ptr <= ptr_next(wr_ptr);
        end
        if (do_pop) begin
            rd_ptr <= ptr_next(rd_ptr);
        end
        case ({do_push, do_pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
        endcase
    end
end

assign empty       = (count == '0);
assign full        = (count == CW'(DEPTH));
assign almost_full = (count >= CW'(PROG_THRESH));

endmodule : sync_fifo

// ==== include/merge_defs.svh ====
/*
 * Build constants for the lane merge unit
 *   lane and field counts
 *   field, meta and merge count widths
 *   FIFO depth and almost-full threshold
 */
`ifndef MERGE_DEFS_SVH
`define MERGE_DEFS_SVH

// Response lanes feeding one merge
`define MERGE_NUM_LANES   4
// Data fields per packet, never fewer than the lane count
`define MERGE_NUM_FIELDS  6

`define MERGE_FIELD_W     32
`define MERGE_META_W      16
`define MERGE_COUNT_W     16

// Shared by lane FIFOs and the output FIFO
`define MERGE_FIFO_DEPTH  16
`define MERGE_PROG_THRESH 8

`endif

// ==== verilog.f ====
+incdir+include
hw/merge_pkg.sv
hw/sync_fifo.sv
hw/merge_control_fsm.sv
hw/merge_collector.sv
hw/output_stage.sv
hw/merge_generator_top.sv
dv/merge_checker.sv
dv/tb_merge_top.sv
